//--- rtl/vic_pkg.sv
package vic_pkg;

   typedef logic [5:0] reg_addr_t;           // register select, adi[5:0]

   // register map, 6510 side
   localparam reg_addr_t reg_ctrl_addr   = 6'h11;  // control, raster bit 8
   localparam reg_addr_t reg_raster_addr = 6'h12;  // raster compare / live line
   localparam reg_addr_t reg_irq_addr    = 6'h19;  // irq enable and acknowledge
   localparam reg_addr_t reg_border_addr = 6'h20;  // border colour
   localparam reg_addr_t reg_bg_addr     = 6'h21;  // background colour

   // control register fields, msb first
   typedef struct packed {
      logic       rst8;     // raster compare bit 8
      logic       ecm;      // extended colour mode
      logic       bmm;      // bitmap mode
      logic       den;      // display enable
      logic       rsel;     // 24/25 row select
      logic [2:0] yscroll;  // fine vertical scroll
   } ctrl_t;

   // one written byte, seen raw or as control fields
   typedef union packed {
      logic [7:0] raw;
      ctrl_t      ctrl;
   } reg_word_u;

   typedef struct packed {
      logic        ce;   // chip enable, low active
      logic        rw;   // 1 = read, 0 = write
      reg_addr_t   adi;  // register address
      logic [11:0] dbi;  // colour nibble over data byte
   } cpu_bus_t;

   typedef struct packed {
      logic [7:0] dbo;     // read data
      logic       dbo_en;  // drive the data bus this cycle
   } bus_drive_t;

endpackage

//--- rtl/video_pkg.sv
package video_pkg;

   typedef logic [3:0] color_t;  // palette index

   typedef struct packed {
      logic [9:0] x;       // dot within line
      logic [8:0] y;       // raster line
      logic       active;  // inside display window
      logic       hsync;
      logic       vsync;
   } raster_pos_t;

   typedef struct packed {
      logic       luma_sink;  // sink luma outside the window
      logic [5:0] luma;
      logic [5:0] chroma;
   } video_out_t;

   // luma per palette entry, black up to white
   localparam logic [5:0] luma_level [16] = '{
      6'h00, 6'h3f, 6'h1a, 6'h2c, 6'h20, 6'h27, 6'h15, 6'h33,
      6'h20, 6'h15, 6'h27, 6'h1a, 6'h24, 6'h33, 6'h24, 6'h2c
   };

   // subcarrier swing around chroma_mid, greys carry none
   localparam logic [5:0] chroma_amp [16] = '{
      6'd0,  6'd0,  6'd10, 6'd8,  6'd10, 6'd10, 6'd10, 6'd6,
      6'd8,  6'd6,  6'd8,  6'd0,  6'd0,  6'd8,  6'd8,  6'd0
   };

   // hue as an offset into the 16 step subcarrier cycle
   localparam logic [3:0] hue_phase [16] = '{
      4'd0, 4'd0, 4'd5, 4'd13, 4'd2, 4'd10, 4'd0, 4'd8,
      4'd7, 4'd6, 4'd5, 4'd0,  4'd0, 4'd10, 4'd0, 4'd0
   };

   localparam logic [5:0] chroma_mid = 6'd32;  // no subcarrier

endpackage

//--- rtl/vic_regs.sv
`timescale 1ns/1ps

module vic_regs (
   input  logic                  clk_col16x_ntsc,
   input  logic                  rst,
   input  vic_pkg::cpu_bus_t     bus,
   input  video_pkg::raster_pos_t pos,
   output vic_pkg::bus_drive_t   drive,
   output video_pkg::color_t     border,
   output video_pkg::color_t     bg,
   output logic                  den,
   output logic                  irq
);

   vic_pkg::ctrl_t    ctrl;        // $11
   logic [7:0]        raster_cmp;  // $12, low 8 bits of compare line
   logic              irq_en;      // raster irq enable, bit 7 of $19
   logic              irq_flag;
   logic              match_q;     // compare hit last cycle
   vic_pkg::reg_word_u wr_word;    // bus byte, raw or as ctrl fields
   logic              wr;
   logic              rd;
   logic              match;
   logic [7:0]        rd_data;

   assign wr      = !bus.ce && !bus.rw;
   assign rd      = !bus.ce && bus.rw;
   assign wr_word.raw = bus.dbi[7:0];  // colour nibble not stored here

   assign match = (pos.y == {ctrl.rst8, raster_cmp});  // 9 bit line compare

   // readback, unused bits float high like the real chip
   always_comb
   begin
      case (bus.adi)
         vic_pkg::reg_ctrl_addr:   rd_data = {pos.y[8], ctrl[6:0]};  // bit 7 is live line bit 8
         vic_pkg::reg_raster_addr: rd_data = pos.y[7:0];  // live line, not compare
         vic_pkg::reg_irq_addr:    rd_data = {irq_en, 6'b111111, irq_flag};
         vic_pkg::reg_border_addr: rd_data = {4'hf, border};
         vic_pkg::reg_bg_addr:     rd_data = {4'hf, bg};
         default:                  rd_data = 8'hff;
      endcase
   end

   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         ctrl       <= '0;
         raster_cmp <= '0;
         irq_en     <= 1'b0;
         border     <= '0;
         bg         <= '0;
         irq_flag   <= 1'b0;
         match_q    <= 1'b0;
         drive.dbo_en <= 1'b0;
      end
      else
      begin
         match_q      <= match;
         drive.dbo_en <= rd;  // one cycle strobe after the read edge
         if (wr)
         begin
            case (bus.adi)
               vic_pkg::reg_ctrl_addr:   ctrl       <= wr_word.ctrl;
               vic_pkg::reg_raster_addr: raster_cmp <= wr_word.raw;
               vic_pkg::reg_border_addr: border     <= wr_word.raw[3:0];
               vic_pkg::reg_bg_addr:     bg         <= wr_word.raw[3:0];
               default: ;
            endcase
         end
         // ack wins over a new hit in the same cycle
         if (wr && bus.adi == vic_pkg::reg_irq_addr)
         begin
            irq_en <= wr_word.raw[7];
            if (wr_word.raw[0])
               irq_flag <= 1'b0;  // write 1 to acknowledge
         end
         else if (match && !match_q && irq_en)
            irq_flag <= 1'b1;  // raster just reached compare line
      end
   end

   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rd)
         drive.dbo <= rd_data;  // payload, only meaningful with dbo_en
   end

   assign den = ctrl.den;
   assign irq = irq_flag;

endmodule

//--- rtl/raster_timer.sv
`timescale 1ns/1ps

module raster_timer #(
   parameter int h_total  = 520,
   parameter int h_active = 320,
   parameter int v_total  = 263,
   parameter int v_active = 200
) (
   input  logic                   clk_col16x_ntsc,
   input  logic                   rst,
   output video_pkg::raster_pos_t pos
);

   localparam logic [9:0] x_last  = 10'(h_total - 1);
   localparam logic [9:0] x_hsync = 10'(h_total - 8);  // last 8 clocks of line
   localparam logic [9:0] x_act   = 10'(h_active);
   localparam logic [8:0] y_last  = 9'(v_total - 1);
   localparam logic [8:0] y_act   = 9'(v_active);

   logic [9:0] x_nxt;
   logic [8:0] y_nxt;

   always_comb
   begin
      x_nxt = pos.x + 10'd1;
      y_nxt = pos.y;
      if (pos.x == x_last)
      begin
         x_nxt = '0;  // end of line
         if (pos.y == y_last)
            y_nxt = '0;  // end of frame
         else
            y_nxt = pos.y + 9'd1;
      end
   end

   // flags from the next count so they land with x and y
   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         pos.x      <= '0;
         pos.y      <= '0;
         pos.active <= (x_act != 10'd0) && (y_act != 9'd0);  // flags for x=0, y=0
         pos.hsync  <= (x_hsync == 10'd0);
         pos.vsync  <= (y_last == 9'd0);
      end
      else
      begin
         pos.x      <= x_nxt;
         pos.y      <= y_nxt;
         pos.active <= (x_nxt < x_act) && (y_nxt < y_act);
         pos.hsync  <= (x_nxt >= x_hsync);
         pos.vsync  <= (y_nxt == y_last);  // one full line per frame
      end
   end

endmodule

//--- rtl/luma_chroma_enc.sv
`timescale 1ns/1ps

module luma_chroma_enc (
   input  logic                   clk_col16x_ntsc,
   input  logic                   rst,
   input  video_pkg::raster_pos_t pos,
   input  video_pkg::color_t      border,
   input  video_pkg::color_t      bg,
   input  logic                   den,
   output video_pkg::video_out_t  vout
);

   logic [3:0]        phase;      // free running subcarrier phase, 16 per cycle
   video_pkg::color_t pix;        // colour of this dot
   logic [3:0]        sub_phase;  // phase shifted by hue
   logic [5:0]        amp;
   logic [5:0]        chroma_nxt;
   logic [5:0]        luma_nxt;

   // window with display on shows background, rest is border
   assign pix = (pos.active && den) ? bg : border;

   assign luma_nxt  = video_pkg::luma_level[pix];
   assign amp       = video_pkg::chroma_amp[pix];
   assign sub_phase = phase + video_pkg::hue_phase[pix];  // wraps mod 16

   // square subcarrier, positive half for phases 0..7
   always_comb
   begin
      if (!sub_phase[3])
         chroma_nxt = video_pkg::chroma_mid + amp;
      else
         chroma_nxt = video_pkg::chroma_mid - amp;
   end

   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
         phase <= '0;
      else
         phase <= phase + 4'd1;  // never stalls
   end

   // all three outputs registered together
   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         vout.luma_sink <= 1'b0;
         vout.luma      <= '0;
         vout.chroma    <= video_pkg::chroma_mid;  // idle, no carrier
      end
      else
      begin
         vout.luma_sink <= !pos.active;  // blank outside window
         vout.luma      <= luma_nxt;
         vout.chroma    <= chroma_nxt;
      end
   end

endmodule

//--- rtl/vic_top.sv
`timescale 1ns/1ps

module vic_top #(
   parameter int h_total  = 520,
   parameter int h_active = 320,
   parameter int v_total  = 263,
   parameter int v_active = 200
) (
   input  logic        clk_col16x_ntsc,  // from pll
   input  logic        rst,
   input  logic        ce,       // low = selected
   input  logic        rw,       // high = read
   input  logic [5:0]  adi,
   input  logic [11:0] dbi,      // {colour nibble, data byte}
   output logic [7:0]  dbo,
   output logic [7:0]  dbo_oe,   // per pin enable
   output logic        irq,
   output logic        hsync,
   output logic        vsync,
   output logic        luma_sink,
   output logic [5:0]  luma,
   output logic [5:0]  chroma,
   output logic        ls245_data_oe,
   output logic        ls245_addr_oe
);

   vic_pkg::cpu_bus_t      bus;
   vic_pkg::bus_drive_t    drive;
   video_pkg::raster_pos_t pos;
   video_pkg::video_out_t  vout;
   video_pkg::color_t      border;
   video_pkg::color_t      bg;
   logic                   den;

   // pins into the bus struct
   assign bus.ce  = ce;
   assign bus.rw  = rw;
   assign bus.adi = adi;
   assign bus.dbi = dbi;

   vic_regs i_vic_regs (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst             (rst),
      .bus             (bus),
      .pos             (pos),
      .drive           (drive),
      .border          (border),
      .bg              (bg),
      .den             (den),
      .irq             (irq)
   );

   raster_timer #(
      .h_total  (h_total),
      .h_active (h_active),
      .v_total  (v_total),
      .v_active (v_active)
   ) i_raster_timer (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst             (rst),
      .pos             (pos)
   );

   luma_chroma_enc i_luma_chroma_enc (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst             (rst),
      .pos             (pos),
      .border          (border),
      .bg              (bg),
      .den             (den),
      .vout            (vout)
   );

   assign dbo    = drive.dbo;        // cpu read data
   assign dbo_oe = {8{drive.dbo_en}}; // same enable on every data pin
   assign hsync  = pos.hsync;
   assign vsync  = pos.vsync;

   assign luma_sink = vout.luma_sink;
   assign luma      = vout.luma;
   assign chroma    = vout.chroma;

   // transceivers stay enabled (low active)
   assign ls245_data_oe = 1'b0;
   assign ls245_addr_oe = 1'b0;

endmodule

//--- tb/vic_top_sva.sv
`timescale 1ns/1ps

module vic_top_sva #(
   parameter int h_total = 520
) (
   input logic                   clk_col16x_ntsc,
   input logic                   rst,
   input logic                   ce,
   input logic                   rw,
   input logic [5:0]             adi,
   input logic [11:0]            dbi,
   input logic [7:0]             dbo_oe,
   input logic                   irq,
   input logic                   hsync,
   input logic                   vsync,
   input logic                   luma_sink,
   input logic [5:0]             luma,
   input logic [5:0]             chroma,
   input logic                   ls245_data_oe,
   input logic                   ls245_addr_oe,
   input video_pkg::raster_pos_t pos,
   input video_pkg::color_t      border,
   input video_pkg::color_t      bg,
   input logic                   den
);

   int                err_cnt = 0;   // read by the testbench top
   video_pkg::color_t pix;           // colour the encoder should pick
   video_pkg::color_t pix_q;         // previous cycle's colour
   logic              act_q;
   int                hold_cnt;      // cycles pix has not changed
   logic              hs_q;
   logic              hs_seen;       // first hsync pulse passed
   int                hs_cnt;        // cycles since last hsync start
   int                vs_len;        // length of the current vsync pulse
   logic              ack;

   // palette entries without colour carrier
   function automatic logic is_grey(input video_pkg::color_t c);
      logic g;
      case (c)
         4'd0, 4'd1, 4'd11, 4'd12, 4'd15: g = 1'b1;
         default:                        g = 1'b0;
      endcase
      return g;
   endfunction

   assign pix = (pos.active && den) ? bg : border;
   assign ack = !ce && !rw && (adi == vic_pkg::reg_irq_addr) && dbi[0];

   always_ff @(posedge clk_col16x_ntsc)
   begin
      if (rst)
      begin
         pix_q    <= '0;
         act_q    <= 1'b0;
         hold_cnt <= 0;
         hs_q     <= 1'b0;
         hs_seen  <= 1'b0;
         hs_cnt   <= 0;
         vs_len   <= 0;
      end
      else
      begin
         pix_q <= pix;
         act_q <= pos.active;
         if (pix != pix_q)
            hold_cnt <= 0;
         else if (hold_cnt < 1000)
            hold_cnt <= hold_cnt + 1;  // saturate
         hs_q <= hsync;
         if (hsync && !hs_q)
         begin
            hs_cnt  <= 1;  // new line starts counting
            hs_seen <= 1'b1;
         end
         else
            hs_cnt <= hs_cnt + 1;
         vs_len <= vsync ? vs_len + 1 : 0;
      end
   end

   // outputs quiet while and right after reset
   a_reset_quiet: assert property (@(posedge clk_col16x_ntsc)
      $past(rst) |-> !irq && !luma_sink && (dbo_oe == 8'h00))
      else begin $error("irq/luma_sink/dbo_oe not low in reset"); err_cnt++; end

   a_ls245_low: assert property (@(posedge clk_col16x_ntsc)
      !ls245_data_oe && !ls245_addr_oe)
      else begin $error("transceiver enable driven high"); err_cnt++; end

   // one dbo_oe pulse per read, on the following cycle only
   a_dbo_oe: assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
      !$past(rst) |-> dbo_oe == ($past(!ce && rw) ? 8'hff : 8'h00))
      else begin $error("dbo_oe 0x%h expected 0x%h", dbo_oe, {8{$past(!ce && rw)}}); err_cnt++; end

   a_luma: assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
      !$past(rst) |-> luma == video_pkg::luma_level[pix_q])
      else begin $error("luma 0x%h expected 0x%h", luma, video_pkg::luma_level[pix_q]); err_cnt++; end

   a_luma_sink: assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
      !$past(rst) |-> luma_sink == !act_q)
      else begin $error("luma_sink 0x%h expected 0x%h", luma_sink, !act_q); err_cnt++; end

   a_chroma_grey: assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
      (!$past(rst) && is_grey(pix_q)) |-> chroma == video_pkg::chroma_mid)
      else begin $error("chroma 0x%h expected 0x%h", chroma, video_pkg::chroma_mid); err_cnt++; end

   // a coloured dot swings to one of two levels around the mid value
   a_chroma_levels: assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
      (!$past(rst) && !is_grey(pix_q)) |->
         chroma == video_pkg::chroma_mid + video_pkg::chroma_amp[pix_q] ||
         chroma == video_pkg::chroma_mid - video_pkg::chroma_amp[pix_q])
      else begin $error("chroma 0x%h off both levels for colour 0x%h", chroma, pix_q); err_cnt++; end

   a_chroma_period: assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
      (hold_cnt >= 20 && !is_grey(pix_q)) |-> chroma == $past(chroma, 16))
      else begin $error("chroma 0x%h expected 0x%h", chroma, $past(chroma, 16)); err_cnt++; end

   // square carrier flips level every half period
   a_chroma_swing: assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
      (hold_cnt >= 20 && !is_grey(pix_q)) |-> chroma != $past(chroma, 8))
      else begin $error("chroma 0x%h equals 0x%h of 8 cycles before", chroma, $past(chroma, 8)); err_cnt++; end

   a_hsync_period: assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
      (hsync && !hs_q && hs_seen) |-> hs_cnt == h_total)
      else begin $error("hs_cnt 0x%h expected 0x%h", hs_cnt, h_total); err_cnt++; end

   a_vsync_line: assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
      (!vsync && $past(vsync)) |-> vs_len == h_total)
      else begin $error("vs_len 0x%h expected 0x%h", vs_len, h_total); err_cnt++; end

   // compare is line 5 throughout the test
   a_irq_line: assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
      $rose(irq) |-> pos.y == 9'd5)
      else begin $error("irq rose on line 0x%h, expected 0x005", pos.y); err_cnt++; end

   a_irq_hold: assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
      (irq && !ack) |=> irq)
      else begin $error("irq dropped without acknowledge"); err_cnt++; end

   a_irq_ack: assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
      ack |=> !irq)
      else begin $error("irq still high after acknowledge"); err_cnt++; end

endmodule

//--- tb/tb_vic_top.sv
`timescale 1ns/1ps

module tb_vic_top;

   localparam int h_total  = 40;
   localparam int h_active = 24;
   localparam int v_total  = 12;
   localparam int v_active = 8;
   localparam int frame    = h_total * v_total;   // clocks per frame
   localparam int limit    = 3 * frame + 200;     // watchdog, in clocks

   logic        clk_col16x_ntsc;
   logic        rst;
   logic        ce;
   logic        rw;
   logic [5:0]  adi;
   logic [11:0] dbi;
   logic [7:0]  dbo;
   logic [7:0]  dbo_oe;
   logic        irq;
   logic        hsync;
   logic        vsync;
   logic        luma_sink;
   logic [5:0]  luma;
   logic [5:0]  chroma;
   logic        ls245_data_oe;
   logic        ls245_addr_oe;

   integer      seed = 35271;
   int          tb_errs = 0;
   int          timeouts = 0;
   logic [3:0]  exp_border;  // model of written colours
   logic [3:0]  exp_bg;

   vic_top #(
      .h_total  (h_total),
      .h_active (h_active),
      .v_total  (v_total),
      .v_active (v_active)
   ) i_vic_top (.*);

   bind vic_top vic_top_sva #(.h_total(h_total)) i_vic_top_sva (
      .clk_col16x_ntsc (clk_col16x_ntsc), .rst (rst), .ce (ce), .rw (rw),
      .adi (adi), .dbi (dbi), .dbo_oe (dbo_oe), .irq (irq),
      .hsync (hsync), .vsync (vsync), .luma_sink (luma_sink), .luma (luma),
      .chroma (chroma), .ls245_data_oe (ls245_data_oe),
      .ls245_addr_oe (ls245_addr_oe), .pos (pos), .border (border),
      .bg (bg), .den (den)
   );

   initial
   begin
      clk_col16x_ntsc = 1'b0;
      forever #5 clk_col16x_ntsc = !clk_col16x_ntsc;
   end

   task automatic bus_write(input logic [5:0] a, input logic [11:0] d);
      @(negedge clk_col16x_ntsc);
      ce  = 1'b0;
      rw  = 1'b0;
      adi = a;
      dbi = d;
      @(negedge clk_col16x_ntsc);
      ce  = 1'b1;  // one cycle strobe
      rw  = 1'b1;
   endtask

   // read one colour register and compare with the model
   task automatic bus_read_colour(input logic [5:0] a, input logic [3:0] nib);
      @(negedge clk_col16x_ntsc);
      ce  = 1'b0;
      rw  = 1'b1;
      adi = a;
      @(negedge clk_col16x_ntsc);
      ce  = 1'b1;
      assert (dbo == {4'hf, nib})
      else
      begin
         $error("dbo 0x%h expected 0x%h", dbo, {4'hf, nib});
         tb_errs++;
      end
   endtask

   task automatic write_colours;
      logic [11:0] d;
      d = 12'($random(seed));
      bus_write(vic_pkg::reg_bg_addr, d);
      exp_bg = d[3:0];
      bus_read_colour(vic_pkg::reg_bg_addr, exp_bg);
      bus_read_colour(vic_pkg::reg_border_addr, exp_border);
   endtask

   task automatic report_and_finish;
      int total;
      total = i_vic_top.i_vic_top_sva.err_cnt + tb_errs + timeouts;
      $display("errors: assertions %0d, testbench %0d, timeouts %0d",
               i_vic_top.i_vic_top_sva.err_cnt, tb_errs, timeouts);
      if (total == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   endtask

   initial
   begin
      repeat (limit + 8) @(posedge clk_col16x_ntsc);
      $display("watchdog expired after %0d clocks, test did not complete", limit);
      timeouts++;
      report_and_finish();
   end

   initial
   begin
      rst = 1'b1;
      ce  = 1'b1;
      rw  = 1'b1;
      adi = '0;
      dbi = '0;
      exp_border = 4'h0;
      exp_bg     = 4'h0;
      repeat (8) @(negedge clk_col16x_ntsc);
      rst = 1'b0;
      bus_write(vic_pkg::reg_ctrl_addr, 12'h010);      // den on
      bus_write(vic_pkg::reg_raster_addr, 12'h005);    // compare line 5
      bus_write(vic_pkg::reg_irq_addr, 12'h080);       // raster irq enable
      bus_write(vic_pkg::reg_border_addr, 12'h002);    // coloured border
      exp_border = 4'h2;
      write_colours();
      while (!irq)
         @(negedge clk_col16x_ntsc);
      repeat (5) @(negedge clk_col16x_ntsc);            // flag must hold
      bus_write(vic_pkg::reg_irq_addr, 12'h081);       // acknowledge, keep enable
      write_colours();
      while (!vsync)
         @(negedge clk_col16x_ntsc);
      while (vsync)
         @(negedge clk_col16x_ntsc);
      bus_write(vic_pkg::reg_border_addr, 12'h00b);    // grey border
      exp_border = 4'hb;
      write_colours();
      repeat (2 * h_total) @(negedge clk_col16x_ntsc);
      report_and_finish();
   end

endmodule

//--- compile.f
rtl/vic_pkg.sv
rtl/video_pkg.sv
rtl/vic_regs.sv
rtl/raster_timer.sv
rtl/luma_chroma_enc.sv
rtl/vic_top.sv
tb/vic_top_sva.sv
tb/tb_vic_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vic_top testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wall -Wno-fatal \
   --top-module tb_vic_top -Mdir obj_dir -f compile.f

# assertion errors must not stop the run early, the testbench counts them
./obj_dir/Vtb_vic_top +verilator+error+limit+10000 > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi
exit 0
